/* common/cp0_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

interface cp0_wr_if import cp0_types_pkg::*; ();
    word_t data;
    logic  wr_index, wr_entrylo0, wr_entrylo1, wr_context;
    logic  wr_count, wr_entryhi, wr_compare, wr_status;
    logic  wr_cause, wr_epc, wr_ebase, wr_config;
    logic  probe_we;
    word_t probe_data;

    modport ctrl (output data, wr_index, wr_entrylo0, wr_entrylo1, wr_context, wr_count,
                  wr_entryhi, wr_compare, wr_status, wr_cause, wr_epc, wr_ebase, wr_config,
                  probe_we, probe_data);
    modport regs (input data, wr_index, wr_entrylo0, wr_entrylo1, wr_context, wr_count,
                  wr_entryhi, wr_compare, wr_status, wr_cause, wr_epc, wr_ebase, wr_config,
                  probe_we, probe_data);
endinterface

interface cp0_exc_if import cp0_types_pkg::*; ();
    logic      exc_take;
    word_t     exc_epc;
    logic      exc_bd;
    exc_code_t exc_code;
    word_t     exc_badv;
    logic      exc_badv_we;
    asid_t     exc_asid;
    logic      exc_asid_we;
    logic      exl_clear;

    modport ctrl (output exc_take, exc_epc, exc_bd, exc_code, exc_badv, exc_badv_we,
                  exc_asid, exc_asid_we, exl_clear);
    modport regs (input exc_take, exc_epc, exc_bd, exc_code, exc_badv, exc_badv_we,
                  exc_asid, exc_asid_we, exl_clear);
endinterface

`default_nettype wire

/* common/cp0_reg_pkg.sv */
`default_nettype none

package cp0_reg_pkg;

    import cp0_types_pkg::*;

    localparam reg_addr_t ADDR_INDEX    = {5'd0,  3'd0};
    localparam reg_addr_t ADDR_ENTRYLO0 = {5'd2,  3'd0};
    localparam reg_addr_t ADDR_ENTRYLO1 = {5'd3,  3'd0};
    localparam reg_addr_t ADDR_CONTEXT  = {5'd4,  3'd0};
    localparam reg_addr_t ADDR_BADVADDR = {5'd8,  3'd0};
    localparam reg_addr_t ADDR_COUNT    = {5'd9,  3'd0};
    localparam reg_addr_t ADDR_ENTRYHI  = {5'd10, 3'd0};
    localparam reg_addr_t ADDR_COMPARE  = {5'd11, 3'd0};
    localparam reg_addr_t ADDR_STATUS   = {5'd12, 3'd0};
    localparam reg_addr_t ADDR_CAUSE    = {5'd13, 3'd0};
    localparam reg_addr_t ADDR_EPC      = {5'd14, 3'd0};
    localparam reg_addr_t ADDR_PRID     = {5'd15, 3'd0};
    localparam reg_addr_t ADDR_EBASE    = {5'd15, 3'd1};
    localparam reg_addr_t ADDR_CONFIG   = {5'd16, 3'd0};
    localparam reg_addr_t ADDR_CONFIG1  = {5'd16, 3'd1};

    localparam word_t STATUS_WMASK  = 32'h1040_FF17; // CU0, BEV, IM, UM, ERL, EXL, IE
    localparam word_t CAUSE_WMASK   = 32'h0080_0300; // IV and the two soft interrupts
    localparam word_t EBASE_WMASK   = 32'h3FFF_F000;
    localparam word_t ENTRYHI_WMASK = 32'hFFFF_E0FF;
    localparam word_t ENTRYLO_WMASK = 32'h3FFF_FFC7; // PFN, V, D, G
    localparam word_t INDEX_WMASK   = 32'h0000_000F;
    localparam word_t CONTEXT_WMASK = 32'hFF80_0000; // PTEBase
    localparam word_t CONFIG_WMASK  = 32'h0000_0007; // K0

    localparam word_t STATUS_RESET  = 32'h0040_0004; // BEV and ERL
    localparam word_t EBASE_RESET   = 32'h8000_0000;

    localparam word_t PRID_VALUE    = 32'h0001_8000;
    localparam word_t CONFIG_CONST  = 32'h8000_0080; // M set, release 1
    localparam word_t CONFIG1_VALUE = 32'h1E00_0000; // 16 TLB entries, no caches

    localparam int COUNT_PRESCALE_BITS = 3;

endpackage

`default_nettype wire

/* common/cp0_types_pkg.sv */
`default_nettype none

package cp0_types_pkg;

    typedef logic [31:0] word_t;

    // Register number in [7:3], select in [2:0]
    typedef logic [7:0]  reg_addr_t;

    typedef logic [4:0]  exc_code_t;
    typedef logic [7:0]  asid_t;

    // Bits 31..13 of a virtual address
    typedef logic [18:0] vpn2_t;

    typedef logic [5:0]  irq_t;

endpackage

`default_nettype wire

/* cp0/cp0_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_ctrl import cp0_types_pkg::*, cp0_reg_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      wr_en_i,
    input  wire reg_addr_t wr_addr_i,
    input  wire word_t     wr_data_i,
    input  wire logic      exc_i,
    input  wire word_t     exc_epc_i,
    input  wire logic      exc_bd_i,
    input  wire exc_code_t exc_code_i,
    input  wire word_t     exc_badv_i,
    input  wire logic      exc_badv_we_i,
    input  wire asid_t     exc_asid_i,
    input  wire logic      exc_asid_we_i,
    input  wire logic      exl_clear_i,
    input  wire logic      probe_we_i,
    input  wire word_t     probe_result_i,
    cp0_wr_if.ctrl         wr,
    cp0_exc_if.ctrl        exc
);

    function automatic logic hit(reg_addr_t addr);
        return wr_en_i && (wr_addr_i == addr);
    endfunction

    assign wr.data        = wr_data_i;
    assign wr.wr_entrylo0 = hit(ADDR_ENTRYLO0);
    assign wr.wr_entrylo1 = hit(ADDR_ENTRYLO1);
    assign wr.wr_context  = hit(ADDR_CONTEXT);
    assign wr.wr_count    = hit(ADDR_COUNT);
    assign wr.wr_entryhi  = hit(ADDR_ENTRYHI);
    assign wr.wr_compare  = hit(ADDR_COMPARE);
    assign wr.wr_status   = hit(ADDR_STATUS);
    assign wr.wr_cause    = hit(ADDR_CAUSE);
    assign wr.wr_ebase    = hit(ADDR_EBASE);
    assign wr.wr_config   = hit(ADDR_CONFIG);
    assign wr.wr_epc      = hit(ADDR_EPC) && !exc_i;        // Exception owns EPC
    assign wr.wr_index    = hit(ADDR_INDEX) && !probe_we_i; // Probe result wins
    assign wr.probe_we    = probe_we_i;
    assign wr.probe_data  = probe_result_i;

    assign exc.exc_take    = exc_i;
    assign exc.exc_epc     = exc_epc_i;
    assign exc.exc_bd      = exc_bd_i;
    assign exc.exc_code    = exc_code_i;
    assign exc.exc_badv    = exc_badv_i;
    assign exc.exc_badv_we = exc_i && exc_badv_we_i;
    assign exc.exc_asid    = exc_asid_i;
    assign exc.exc_asid_we = exc_i && exc_asid_we_i;
    assign exc.exl_clear   = exl_clear_i;

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({wr.wr_index, wr.wr_entrylo0, wr.wr_entrylo1, wr.wr_context, wr.wr_count,
                  wr.wr_entryhi, wr.wr_compare, wr.wr_status, wr.wr_cause, wr.wr_epc,
                  wr.wr_ebase, wr.wr_config}));

endmodule

`default_nettype wire

/* cp0/cp0_status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_status_regs import cp0_types_pkg::*, cp0_reg_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    cp0_wr_if.regs    wr,
    cp0_exc_if.regs   exc,
    output word_t     status_o,
    output word_t     cause_o,
    output word_t     epc_o,
    output word_t     ebase_o,
    output word_t     badvaddr_o,
    output word_t     config_o
);

    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    word_t ebase_q;
    word_t badvaddr_q;
    word_t config_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= STATUS_RESET;
            cause_q  <= '0;
            ebase_q  <= EBASE_RESET;
            config_q <= '0;
        end else begin
            if (wr.wr_status)
                status_q <= (status_q & ~STATUS_WMASK) | (wr.data & STATUS_WMASK);
            // Exception return beats exception entry
            if (exc.exl_clear)
                status_q[1] <= 1'b0; // EXL
            else if (exc.exc_take)
                status_q[1] <= 1'b1;

            if (wr.wr_cause)
                cause_q <= (cause_q & ~CAUSE_WMASK) | (wr.data & CAUSE_WMASK);
            if (exc.exc_take) begin
                cause_q[31]  <= exc.exc_bd;
                cause_q[6:2] <= exc.exc_code;
            end

            if (wr.wr_ebase)
                ebase_q <= (ebase_q & ~EBASE_WMASK) | (wr.data & EBASE_WMASK);
            if (wr.wr_config)
                config_q <= wr.data & CONFIG_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.exc_take)
            epc_q <= exc.exc_epc;
        else if (wr.wr_epc)
            epc_q <= wr.data;
        if (exc.exc_badv_we)
            badvaddr_q <= exc.exc_badv;
    end

    assign status_o   = status_q;
    assign cause_o    = cause_q;
    assign epc_o      = epc_q;
    assign ebase_o    = ebase_q;
    assign badvaddr_o = badvaddr_q;
    assign config_o   = config_q;

    a_exl_clear_wins: assert property (@(posedge clk) disable iff (!rst_n)
        exc.exl_clear |=> !status_q[1]);

endmodule

`default_nettype wire

/* cp0/cp0_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_timer import cp0_types_pkg::*, cp0_reg_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    cp0_wr_if.regs    wr,
    output word_t     count_o,
    output word_t     compare_o,
    output logic      timer_int_o
);

    logic [COUNT_PRESCALE_BITS-1:0] presc_q;
    word_t count_q;
    word_t compare_q;
    logic  match;

    assign match = (compare_q != '0) && (count_q == compare_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_q     <= '0;
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_o <= 1'b0;
        end else begin
            presc_q <= presc_q + 1'b1; // Free running from reset
            if (wr.wr_count)
                count_q <= wr.data;
            else if (&presc_q)
                count_q <= count_q + 32'd1;
            if (wr.wr_compare) begin
                compare_q   <= wr.data;
                timer_int_o <= 1'b0; // Compare write acknowledges
            end else if (match) begin
                timer_int_o <= 1'b1;
            end
        end
    end

    assign count_o   = count_q;
    assign compare_o = compare_q;

    a_int_after_match: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(timer_int_o) |-> $past(match));

endmodule

`default_nettype wire

/* cp0/cp0_tlb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_tlb_regs import cp0_types_pkg::*, cp0_reg_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    cp0_wr_if.regs    wr,
    cp0_exc_if.regs   exc,
    output word_t     index_o,
    output word_t     entrylo0_o,
    output word_t     entrylo1_o,
    output word_t     entryhi_o,
    output word_t     context_o
);

    word_t       index_q;
    word_t       entrylo0_q;
    word_t       entrylo1_q;
    word_t       entryhi_q;
    logic [31:4] context_q;
    vpn2_t       bad_vpn2;

    assign bad_vpn2 = exc.exc_badv[31:13];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q   <= '0;
            entryhi_q <= '0;
        end else begin
            if (wr.probe_we)
                index_q <= wr.probe_data; // P bit plus matching entry
            if (wr.wr_index)
                index_q <= (index_q & ~INDEX_WMASK) | (wr.data & INDEX_WMASK);

            if (wr.wr_entryhi)
                entryhi_q <= (entryhi_q & ~ENTRYHI_WMASK) | (wr.data & ENTRYHI_WMASK);
            if (exc.exc_take)
                entryhi_q[31:13] <= bad_vpn2;
            if (exc.exc_asid_we)
                entryhi_q[7:0] <= exc.exc_asid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wr_entrylo0)
            entrylo0_q <= wr.data & ENTRYLO_WMASK;
        if (wr.wr_entrylo1)
            entrylo1_q <= wr.data & ENTRYLO_WMASK;
        if (wr.wr_context)
            context_q[31:23] <= wr.data[31:23];
        if (exc.exc_take)
            context_q[22:4] <= bad_vpn2;
    end

    assign index_o    = index_q;
    assign entrylo0_o = entrylo0_q;
    assign entrylo1_o = entrylo1_q;
    assign entryhi_o  = entryhi_q;
    assign context_o  = {context_q, 4'b0};

endmodule

`default_nettype wire

/* project.f */
common/cp0_types_pkg.sv
common/cp0_reg_pkg.sv
common/cp0_ifs.sv
cp0/cp0_ctrl.sv
cp0/cp0_timer.sv
cp0/cp0_status_regs.sv
cp0/cp0_tlb_regs.sv
source/cp0_read_mux.sv
source/cp0_top.sv
test/cp0_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the CP0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cp0_tb -f project.f -o cp0_sim \
    > build.log 2>&1 \
    && ./obj_dir/cp0_sim > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Some tests failed" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "All tests passed" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"

/* source/cp0_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_read_mux import cp0_types_pkg::*, cp0_reg_pkg::*; (
    input  wire reg_addr_t rd_addr_i,
    input  wire reg_addr_t dbg_rd_addr_i,
    input  wire irq_t      hw_int_i,
    input  wire word_t     status_i,
    input  wire word_t     cause_i,
    input  wire word_t     epc_i,
    input  wire word_t     ebase_i,
    input  wire word_t     badvaddr_i,
    input  wire word_t     config_i,
    input  wire word_t     count_i,
    input  wire word_t     compare_i,
    input  wire word_t     index_i,
    input  wire word_t     entrylo0_i,
    input  wire word_t     entrylo1_i,
    input  wire word_t     entryhi_i,
    input  wire word_t     context_i,
    output word_t          rd_data_o,
    output word_t          dbg_rd_data_o
);

    function automatic word_t read_view(reg_addr_t addr);
        word_t v;
        case (addr)
            ADDR_INDEX:    v = {index_i[31], 27'b0, index_i[3:0]};
            ADDR_ENTRYLO0: v = entrylo0_i & ENTRYLO_WMASK;
            ADDR_ENTRYLO1: v = entrylo1_i & ENTRYLO_WMASK;
            ADDR_CONTEXT:  v = {context_i[31:4], 4'b0};
            ADDR_BADVADDR: v = badvaddr_i;
            ADDR_COUNT:    v = count_i;
            ADDR_ENTRYHI:  v = entryhi_i & ENTRYHI_WMASK;
            ADDR_COMPARE:  v = compare_i;
            ADDR_STATUS:   v = status_i & STATUS_WMASK;
            ADDR_CAUSE:    v = {cause_i[31], 7'b0, cause_i[23], 7'b0, hw_int_i,
                                cause_i[9:8], 1'b0, cause_i[6:2], 2'b0}; // IP7..2 live
            ADDR_EPC:      v = epc_i;
            ADDR_PRID:     v = PRID_VALUE;
            ADDR_EBASE:    v = {2'b10, ebase_i[29:12], 12'b0}; // kseg0 only
            ADDR_CONFIG:   v = CONFIG_CONST | (config_i & CONFIG_WMASK);
            ADDR_CONFIG1:  v = CONFIG1_VALUE;
            default:       v = '0;
        endcase
        return v;
    endfunction

    always_comb begin
        rd_data_o     = read_view(rd_addr_i);
        dbg_rd_data_o = read_view(dbg_rd_addr_i);
    end

endmodule

`default_nettype wire

/* source/cp0_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_top import cp0_types_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      wr_en_i,
    input  wire reg_addr_t wr_addr_i,
    input  wire word_t     wr_data_i,
    input  wire reg_addr_t rd_addr_i,
    output word_t          rd_data_o,
    input  wire reg_addr_t dbg_rd_addr_i,
    output word_t          dbg_rd_data_o,
    input  wire irq_t      hw_int_i,
    input  wire logic      exc_i,
    input  wire word_t     exc_epc_i,
    input  wire logic      exc_bd_i,
    input  wire exc_code_t exc_code_i,
    input  wire word_t     exc_badv_i,
    input  wire logic      exc_badv_we_i,
    input  wire asid_t     exc_asid_i,
    input  wire logic      exc_asid_we_i,
    input  wire logic      exl_clear_i,
    input  wire logic      probe_we_i,
    input  wire word_t     probe_result_i,
    output logic           timer_int_o,
    output logic           user_mode_o,
    output logic           allow_int_o,
    output logic           in_exl_o,
    output logic           boot_exp_vec_o,
    output logic           special_int_vec_o,
    output logic [7:0]     int_mask_o,
    output logic [1:0]     soft_int_o,
    output logic [19:0]    ebase_o,
    output word_t          epc_o,
    output asid_t          asid_o,
    output logic [83:0]    tlb_config_o
);

    word_t status, cause, epc, ebase, badvaddr, config_w;
    word_t count, compare;
    word_t index, entrylo0, entrylo1, entryhi, context_w;

    cp0_wr_if  wr_bus ();
    cp0_exc_if exc_bus ();

    cp0_ctrl cp0_ctrl_inst (
        .clk, .rst_n, .wr_en_i, .wr_addr_i, .wr_data_i,
        .exc_i, .exc_epc_i, .exc_bd_i, .exc_code_i, .exc_badv_i, .exc_badv_we_i,
        .exc_asid_i, .exc_asid_we_i, .exl_clear_i, .probe_we_i, .probe_result_i,
        .wr(wr_bus.ctrl), .exc(exc_bus.ctrl)
    );

    cp0_timer cp0_timer_inst (
        .clk, .rst_n, .wr(wr_bus.regs),
        .count_o(count), .compare_o(compare), .timer_int_o
    );

    cp0_status_regs cp0_status_regs_inst (
        .clk, .rst_n, .wr(wr_bus.regs), .exc(exc_bus.regs),
        .status_o(status), .cause_o(cause), .epc_o(epc), .ebase_o(ebase),
        .badvaddr_o(badvaddr), .config_o(config_w)
    );

    cp0_tlb_regs cp0_tlb_regs_inst (
        .clk, .rst_n, .wr(wr_bus.regs), .exc(exc_bus.regs),
        .index_o(index), .entrylo0_o(entrylo0), .entrylo1_o(entrylo1),
        .entryhi_o(entryhi), .context_o(context_w)
    );

    cp0_read_mux cp0_read_mux_inst (
        .rd_addr_i, .dbg_rd_addr_i, .hw_int_i,
        .status_i(status), .cause_i(cause), .epc_i(epc), .ebase_i(ebase),
        .badvaddr_i(badvaddr), .config_i(config_w), .count_i(count), .compare_i(compare),
        .index_i(index), .entrylo0_i(entrylo0), .entrylo1_i(entrylo1),
        .entryhi_i(entryhi), .context_i(context_w),
        .rd_data_o, .dbg_rd_data_o
    );

    assign user_mode_o       = (status[4:1] == 4'b1000); // UM with ERL and EXL clear
    assign allow_int_o       = (status[2:0] == 3'b001);
    assign in_exl_o          = status[1];
    assign boot_exp_vec_o    = status[22];
    assign int_mask_o        = status[15:8];
    assign special_int_vec_o = cause[23];
    assign soft_int_o        = cause[9:8];
    assign ebase_o           = {2'b10, ebase[29:12]};
    assign epc_o             = epc;
    assign asid_o            = entryhi[7:0];

    // Entry pair for TLBWI with G as the AND of both halves
    assign tlb_config_o = {
        entryhi[7:0],
        entrylo1[0] & entrylo0[0],
        entryhi[31:13],
        entrylo1[29:6],
        entrylo1[2:1],
        entrylo0[29:6],
        entrylo0[2:1],
        index[3:0]
    };

endmodule

`default_nettype wire

/* test/cp0_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_tb import cp0_types_pkg::*, cp0_reg_pkg::*;;

    localparam int N_STEPS = 15;
    localparam int TIMEOUT = N_STEPS * 40 + 200;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        word_t     expect_val;
    } step_t;

    logic clk = 1'b0;
    logic rst_n;
    logic wr_en_i, exc_i, exc_bd_i, exc_badv_we_i, exc_asid_we_i, exl_clear_i, probe_we_i;
    reg_addr_t wr_addr_i, rd_addr_i, dbg_rd_addr_i;
    word_t wr_data_i, exc_epc_i, exc_badv_i, probe_result_i, rd_data_o, dbg_rd_data_o;
    word_t epc_o;
    irq_t hw_int_i;
    exc_code_t exc_code_i;
    asid_t exc_asid_i, asid_o;
    logic timer_int_o, user_mode_o, allow_int_o, in_exl_o, boot_exp_vec_o, special_int_vec_o;
    logic [7:0] int_mask_o;
    logic [1:0] soft_int_o;
    logic [19:0] ebase_o;
    logic [83:0] tlb_config_o;

    step_t steps[N_STEPS];
    int errors = 0;
    int cycles = 0;

    cp0_top cp0_top_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Run did not finish within %0d cycles", TIMEOUT);
            $display("Some tests failed");
            $finish;
        end
    end

    // Read view of a register right after writing data to it
    function automatic word_t expected_read(reg_addr_t addr, word_t data);
        case (addr)
            ADDR_INDEX:    return data & INDEX_WMASK;
            ADDR_ENTRYLO0: return data & ENTRYLO_WMASK;
            ADDR_ENTRYLO1: return data & ENTRYLO_WMASK;
            ADDR_ENTRYHI:  return data & ENTRYHI_WMASK;
            ADDR_COUNT:    return data;
            ADDR_COMPARE:  return data;
            ADDR_STATUS:   return data & STATUS_WMASK;
            ADDR_CAUSE:    return data & CAUSE_WMASK;
            ADDR_EPC:      return data;
            ADDR_EBASE:    return EBASE_RESET | (data & EBASE_WMASK);
            ADDR_CONFIG:   return CONFIG_CONST | (data & CONFIG_WMASK);
            ADDR_PRID:     return PRID_VALUE;
            ADDR_CONFIG1:  return CONFIG1_VALUE;
            default:       return '0;
        endcase
    endfunction

    task automatic check(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_wide(string name, logic [83:0] got, logic [83:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(reg_addr_t addr, word_t data);
        @(negedge clk);
        wr_en_i   = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        @(negedge clk);
        wr_en_i   = 1'b0;
    endtask

    // Both ports must agree in the same cycle
    task automatic read_check(string name, reg_addr_t addr, word_t exp);
        rd_addr_i     = addr;
        dbg_rd_addr_i = addr;
        #1;
        check(name, rd_data_o, exp);
        check({name, " (debug port)"}, dbg_rd_data_o, exp);
    endtask

    task automatic take_exception(word_t epc, logic bd, exc_code_t code, word_t badv,
                                  logic badv_we, asid_t asid, logic asid_we);
        @(negedge clk);
        exc_i         = 1'b1;
        exc_epc_i     = epc;
        exc_bd_i      = bd;
        exc_code_i    = code;
        exc_badv_i    = badv;
        exc_badv_we_i = badv_we;
        exc_asid_i    = asid;
        exc_asid_we_i = asid_we;
        wr_en_i       = 1'b1; // Competing EPC write
        wr_addr_i     = ADDR_EPC;
        wr_data_i     = ~epc;
        @(negedge clk);
        exc_i   = 1'b0;
        wr_en_i = 1'b0;
    endtask

    task automatic add_step(int i, reg_addr_t addr);
        steps[i].addr       = addr;
        steps[i].data       = $urandom;
        steps[i].expect_val = expected_read(addr, steps[i].data);
    endtask

    initial begin
        word_t b1, b2, cnt, d, lo0, lo1, ehi, p;
        asid_t a1;
        exc_code_t c1;
        irq_t hw;
        logic [83:0] exp_tlb;

        void'($urandom(91));
        rst_n = 1'b0;
        {wr_en_i, exc_i, exc_bd_i, exc_badv_we_i, exc_asid_we_i} = '0;
        {exl_clear_i, probe_we_i} = '0;
        wr_addr_i = '0;
        rd_addr_i = '0;
        dbg_rd_addr_i = '0;
        {wr_data_i, exc_epc_i, exc_badv_i, probe_result_i} = '0;
        hw_int_i = '0;
        exc_code_i = '0;
        exc_asid_i = '0;

        add_step(0, ADDR_INDEX);
        add_step(1, ADDR_ENTRYLO0);
        add_step(2, ADDR_ENTRYLO1);
        add_step(3, ADDR_ENTRYHI);
        add_step(4, ADDR_COUNT);
        add_step(5, ADDR_COMPARE);
        add_step(6, ADDR_STATUS);
        add_step(7, ADDR_CAUSE);
        add_step(8, ADDR_EPC);
        add_step(9, ADDR_EBASE);
        add_step(10, ADDR_CONFIG);
        add_step(11, ADDR_PRID);
        add_step(12, ADDR_CONFIG1);
        add_step(13, {5'd20, 3'd0});
        add_step(14, {5'd15, 3'd2});

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        read_check("Status", ADDR_STATUS, STATUS_RESET);
        read_check("EBase", ADDR_EBASE, EBASE_RESET);
        read_check("Count", ADDR_COUNT, '0);
        read_check("Compare", ADDR_COMPARE, '0);
        check("timer_int_o", word_t'(timer_int_o), 0);
        check("in_exl_o", word_t'(in_exl_o), 0);
        check("allow_int_o", word_t'(allow_int_o), 0);
        check("user_mode_o", word_t'(user_mode_o), 0);
        check("boot_exp_vec_o", word_t'(boot_exp_vec_o), 1);

        foreach (steps[i]) begin
            write_reg(steps[i].addr, steps[i].data);
            read_check($sformatf("rd_data_o @%h", steps[i].addr), steps[i].addr,
                       steps[i].expect_val);
        end

        // The two ports decode their own addresses
        rd_addr_i     = ADDR_PRID;
        dbg_rd_addr_i = ADDR_CONFIG1;
        #1;
        check("rd_data_o", rd_data_o, PRID_VALUE);
        check("dbg_rd_data_o", dbg_rd_data_o, CONFIG1_VALUE);

        // Exception entry
        write_reg(ADDR_STATUS, '0);
        write_reg(ADDR_CAUSE, '0);
        b1 = $urandom;
        a1 = 8'h5a;
        c1 = 5'h0c;
        take_exception(32'h8000_1234, 1'b1, c1, b1, 1'b1, a1, 1'b1);
        read_check("EPC", ADDR_EPC, 32'h8000_1234);
        check("epc_o", epc_o, 32'h8000_1234);
        read_check("Cause", ADDR_CAUSE, {1'b1, 24'b0, c1, 2'b0});
        read_check("BadVAddr", ADDR_BADVADDR, b1);
        read_check("EntryHi", ADDR_ENTRYHI, {b1[31:13], 5'b0, a1});
        check("in_exl_o", word_t'(in_exl_o), 1);
        d = $urandom;
        write_reg(ADDR_CONTEXT, d);
        read_check("Context", ADDR_CONTEXT, (d & CONTEXT_WMASK) | {9'b0, b1[31:13], 4'b0});
        b2 = $urandom;
        take_exception(32'h8000_2000, 1'b0, 5'h03, b2, 1'b0, 8'hff, 1'b0);
        read_check("BadVAddr kept", ADDR_BADVADDR, b1);
        read_check("EntryHi", ADDR_ENTRYHI, {b2[31:13], 5'b0, a1});
        read_check("Cause", ADDR_CAUSE, {27'b0, 5'h03, 2'b0} & 32'h0000_007C);
        @(negedge clk);
        exl_clear_i = 1'b1;
        @(negedge clk);
        exl_clear_i = 1'b0;
        check("in_exl_o", word_t'(in_exl_o), 0);

        // Timer
        cnt = $urandom & 32'h00ff_ffff;
        write_reg(ADDR_COUNT, cnt);
        repeat (24) @(negedge clk);
        read_check("Count after 3 ticks", ADDR_COUNT, cnt + 3);
        write_reg(ADDR_COMPARE, cnt + 32'd6);
        for (int k = 0; k < 48; k++) begin
            if (timer_int_o)
                break;
            @(negedge clk);
        end
        if (!timer_int_o) begin
            $display("Timer interrupt did not rise after Count reached Compare");
            errors++;
        end
        write_reg(ADDR_COMPARE, '0);
        check("timer_int_o after Compare write", word_t'(timer_int_o), 0);

        // Probe against Index write
        p = 32'h8000_0005;
        @(negedge clk);
        probe_we_i     = 1'b1;
        probe_result_i = p;
        wr_en_i        = 1'b1;
        wr_addr_i      = ADDR_INDEX;
        wr_data_i      = 32'h0000_000a;
        @(negedge clk);
        probe_we_i = 1'b0;
        wr_en_i    = 1'b0;
        hw = irq_t'($urandom);
        hw_int_i = hw;
        read_check("Index", ADDR_INDEX, p);
        read_check("Cause live IP", ADDR_CAUSE, {16'b0, hw, 3'b0, 5'h03, 2'b0});

        // Derived levels
        write_reg(ADDR_STATUS, 32'h0000_0011);
        check("user_mode_o", word_t'(user_mode_o), 1);
        check("allow_int_o", word_t'(allow_int_o), 1);
        write_reg(ADDR_STATUS, 32'h0000_a501);
        check("int_mask_o", word_t'(int_mask_o), 32'h0000_00a5);
        check("user_mode_o", word_t'(user_mode_o), 0);
        check("allow_int_o", word_t'(allow_int_o), 1);
        write_reg(ADDR_STATUS, 32'h0000_0013);
        check("allow_int_o with EXL", word_t'(allow_int_o), 0);
        write_reg(ADDR_CAUSE, 32'h0080_0300);
        check("special_int_vec_o", word_t'(special_int_vec_o), 1);
        check("soft_int_o", word_t'(soft_int_o), 32'h0000_0003);
        write_reg(ADDR_EBASE, 32'h1234_5000);
        check("ebase_o", word_t'(ebase_o), word_t'({2'b10, 18'h12345}));
        lo0 = $urandom & ENTRYLO_WMASK;
        lo1 = $urandom & ENTRYLO_WMASK;
        ehi = $urandom & ENTRYHI_WMASK;
        write_reg(ADDR_ENTRYLO0, lo0);
        write_reg(ADDR_ENTRYLO1, lo1);
        write_reg(ADDR_ENTRYHI, ehi);
        write_reg(ADDR_INDEX, 32'h0000_0003);
        check("asid_o", word_t'(asid_o), word_t'(ehi[7:0]));
        exp_tlb = {ehi[7:0], lo1[0] & lo0[0], ehi[31:13], lo1[29:6], lo1[2:1],
                   lo0[29:6], lo0[2:1], 4'h3};
        check_wide("tlb_config_o", tlb_config_o, exp_tlb);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
